// ==== Bender.yml ====
package:
  name: simulation_pll

sources:
  # design, in compile order.
  - design/sim_pll_pkg.sv
  - design/clock_period_counter.sv
  - design/toggle_delay_calc.sv
  - design/squarewave_dds.sv
  - design/lock_detector.sv
  - design/simulation_pll.sv

  # testbench and bound checker.
  - target: test
    files:
      - tests/simulation_pll_checker.sv
      - tests/simulation_pll_tb.sv

// ==== build.f ====
design/sim_pll_pkg.sv
design/clock_period_counter.sv
design/toggle_delay_calc.sv
design/squarewave_dds.sv
design/lock_detector.sv
design/simulation_pll.sv
tests/simulation_pll_checker.sv
tests/simulation_pll_tb.sv

// ==== design/clock_period_counter.sv ====
`default_nettype none

// measures refclk period by timestamping each rising edge.
// period_valid pulses for one cycle per new measurement,
// starting once two edges have been seen after reset.
module clock_period_counter import sim_pll_pkg::*; (
	input  logic       refclk,
	input  logic       rst,
	output period_ps_t period_ps,
	output logic       period_valid
);

	timeunit 1ps;
	timeprecision 1ps;

	time        last_edge_ps; // stamp of the previous rising edge.
	logic [1:0] edge_cnt;     // saturates at two edges.

	always_ff @(posedge refclk) begin
		if (rst) begin
			edge_cnt     <= 2'd0;
			last_edge_ps <= 0;
			period_ps    <= '0; // keeps the dds idle.
			period_valid <= 1'b0;
		end else begin
			period_valid <= 1'b0; // default, strobe only.
			last_edge_ps <= $time;

			// count edges until a full period is available.
			if (edge_cnt != 2'd2)
				edge_cnt <= edge_cnt + 2'd1;

			// second edge onward has a previous stamp.
			if (edge_cnt != 2'd0) begin
				period_ps    <= period_ps_t'($time - last_edge_ps);
				period_valid <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/lock_detector.sv ====
`default_nettype none

// reports lock once LOCK_COUNT consecutive period measurements
// agree within TOLERANCE_PS and the multiplier has held still.
module lock_detector import sim_pll_pkg::*; #(
	parameter int LOCK_COUNT   = 4,
	parameter int TOLERANCE_PS = 2
) (
	input  logic        refclk,
	input  logic        rst,
	input  period_ps_t  period_ps,
	input  logic        period_valid,
	input  multiplier_t multiplier,
	output logic        locked
);

	timeunit 1ps;
	timeprecision 1ps;

	localparam int CNT_W = $clog2(LOCK_COUNT + 1);

	lock_state_t state;
	logic [CNT_W-1:0] stable_cnt; // measurements in the current run.
	period_ps_t  last_period;
	multiplier_t last_mult;
	period_ps_t  delta;           // abs change from the last period.
	logic        stable;

	always_comb begin
		delta  = (period_ps > last_period) ? period_ps - last_period
		                                   : last_period - period_ps;
		stable = (delta <= period_ps_t'(TOLERANCE_PS));
	end

	always_ff @(posedge refclk) begin
		if (rst) begin
			state       <= LOCK_IDLE;
			stable_cnt  <= '0;
			last_period <= '0;
			last_mult   <= '0;
		end else begin
			last_mult <= multiplier;
			if (multiplier != last_mult) begin
				state      <= LOCK_IDLE; // ratio changed, start over.
				stable_cnt <= '0;
			end else if (period_valid) begin
				last_period <= period_ps;
				unique case (state)
					LOCK_IDLE: begin
						stable_cnt <= CNT_W'(1); // first of the run.
						state      <= (LOCK_COUNT <= 1) ? LOCK_LOCKED : LOCK_COUNTING;
					end
					LOCK_COUNTING: begin
						if (!stable)
							stable_cnt <= CNT_W'(1); // run restarts here.
						else if (stable_cnt >= CNT_W'(LOCK_COUNT - 1))
							state <= LOCK_LOCKED;
						else
							stable_cnt <= stable_cnt + CNT_W'(1);
					end
					LOCK_LOCKED: begin
						if (!stable) begin
							state      <= LOCK_COUNTING;
							stable_cnt <= CNT_W'(1);
						end
					end
					default: state <= LOCK_IDLE;
				endcase
			end
		end
	end

	assign locked = (state == LOCK_LOCKED);

endmodule

`default_nettype wire

// ==== design/sim_pll_pkg.sv ====
`default_nettype none

// shared types for the simulation pll model.
package sim_pll_pkg;

	// time span in picoseconds.
	typedef logic [31:0] period_ps_t;

	// integer ratio of output to reference frequency.
	// zero is not a legal value.
	typedef logic [31:0] multiplier_t;

	// fraction of a picosecond, lsb is 2^-32 ps.
	typedef logic [31:0] frac_t;

	// one whole picosecond expressed in frac_t units.
	localparam real FRAC_SCALE = 4294967296.0;

	// lock detector states.
	typedef enum logic [1:0] {
		LOCK_IDLE     = 2'd0, // no period seen yet.
		LOCK_COUNTING = 2'd1, // counting stable periods.
		LOCK_LOCKED   = 2'd2  // lock reported.
	} lock_state_t;

endpackage

`default_nettype wire

// ==== design/simulation_pll.sv ====
`default_nettype none

// simulation clock multiplier.
// clkout runs at the refclk frequency times multiplier.
module simulation_pll import sim_pll_pkg::*; #(
	parameter int LOCK_COUNT   = 4, // stable measurements for lock.
	parameter int TOLERANCE_PS = 2  // allowed period drift in ps.
) (
	input  logic        refclk,
	input  logic        rst,
	input  multiplier_t multiplier,
	output logic        clkout,
	output logic        locked
);

	timeunit 1ps;
	timeprecision 1ps;

	period_ps_t period_ps;    // measured refclk period.
	logic       period_valid; // new measurement strobe.
	period_ps_t real_part;    // whole ps of the half period.
	frac_t      frac_part;    // fraction of the half period.

	// measure the reference.
	clock_period_counter counter_i (
		.refclk       (refclk),
		.rst          (rst),
		.period_ps    (period_ps),
		.period_valid (period_valid)
	);

	// output half period from the measured one.
	toggle_delay_calc calc_i (
		.period_ps  (period_ps),
		.multiplier (multiplier),
		.real_part  (real_part),
		.frac_part  (frac_part)
	);

	// generate the multiplied clock.
	squarewave_dds dds_i (
		.rst       (rst),
		.real_part (real_part),
		.frac_part (frac_part),
		.clkout    (clkout)
	);

	lock_detector #(
		.LOCK_COUNT   (LOCK_COUNT),
		.TOLERANCE_PS (TOLERANCE_PS)
	) lock_i (
		.refclk       (refclk),
		.rst          (rst),
		.period_ps    (period_ps),
		.period_valid (period_valid),
		.multiplier   (multiplier),
		.locked       (locked)
	);

endmodule

`default_nettype wire

// ==== design/squarewave_dds.sv ====
`default_nettype none

// unclocked square wave generator.
// each half cycle lasts real_part ps, plus one ps when the
// fraction accumulator carries, so the average half period
// is real_part + frac_part * 2^-32 ps.
module squarewave_dds import sim_pll_pkg::*; (
	input  logic       rst,
	input  period_ps_t real_part,
	input  frac_t      frac_part,
	output logic       clkout
);

	timeunit 1ps;
	timeprecision 1ps;

	frac_t      acc;   // phase fraction accumulator.
	logic       carry; // accumulator overflow, adds one ps.
	period_ps_t step;  // length of the current half cycle.

	always begin
		if (rst !== 1'b0 || real_part == '0 ||
			$isunknown(real_part) || $isunknown(frac_part)) begin
			// idle. output low, phase cleared.
			clkout = 1'b0;
			acc    = '0;
			carry  = 1'b0;
			@(rst or real_part or frac_part);
		end else begin
			// delays are sampled here, so a new value
			// applies from the next toggle on.
			{carry, acc} = {1'b0, acc} + {1'b0, frac_part};
			step         = real_part + period_ps_t'(carry);

			// reset cuts the half cycle short.
			fork
				#(step);
				@(posedge rst);
			join_any
			disable fork;

			if (rst === 1'b0)
				clkout = ~clkout; // next half cycle.
		end
	end

endmodule

`default_nettype wire

// ==== design/toggle_delay_calc.sv ====
`default_nettype none

// half period of the output clock, P / (2M).
// split into whole ps and a 32 bit binary fraction.
module toggle_delay_calc import sim_pll_pkg::*; (
	input  period_ps_t  period_ps,
	input  multiplier_t multiplier,
	output period_ps_t  real_part,
	output frac_t       frac_part
);

	timeunit 1ps;
	timeprecision 1ps;

	real half_r;  // exact half period in ps.
	real whole_r; // floor of the half period.
	real frac_r;  // leftover below one ps.

	always_comb begin
		// defaults hold the generator idle.
		half_r    = 0.0;
		whole_r   = 0.0;
		frac_r    = 0.0;
		real_part = '0;
		frac_part = '0;

		// no period yet, or an illegal ratio.
		if (period_ps != '0 && multiplier != '0) begin
			half_r  = real'(period_ps) / (2.0 * real'(multiplier));
			whole_r = $floor(half_r);
			frac_r  = (half_r - whole_r) * FRAC_SCALE;

			real_part = period_ps_t'(longint'(whole_r));
			// floor first, a rounding cast could wrap to zero.
			frac_part = frac_t'(longint'($floor(frac_r)));
		end
	end

endmodule

`default_nettype wire

// ==== tests/simulation_pll_checker.sv ====
`default_nettype none

// reset and lock rules for simulation_pll.
module simulation_pll_checker import sim_pll_pkg::*; (
	input logic        refclk,
	input logic        rst,
	input multiplier_t multiplier,
	input logic        clkout,
	input logic        locked
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0; // failed assertions so far.

	// locked stays low through reset and one cycle beyond.
	locked_low_in_reset: assert property (
		@(posedge refclk) rst |=> !locked ##1 !locked
	) else begin
		fail_cnt++;
		$error("locked high during or right after reset");
	end

	// clkout never rises while rst is high.
	clkout_low_in_reset: assert property (
		@(posedge clkout) !rst
	) else begin
		fail_cnt++;
		$error("clkout rose while rst is high");
	end

	// a new ratio restarts the lock count.
	locked_drops_on_change: assert property (
		@(posedge refclk) disable iff (rst)
		(multiplier != $past(multiplier)) |=> !locked
	) else begin
		fail_cnt++;
		$error("locked still high after a multiplier change");
	end

endmodule

// every simulation_pll instance gets a checker.
bind simulation_pll simulation_pll_checker checker_i (
	.refclk     (refclk),
	.rst        (rst),
	.multiplier (multiplier),
	.clkout     (clkout),
	.locked     (locked)
);

`default_nettype wire

// ==== tests/simulation_pll_stim.txt ====
# columns: test name, multiplier, expected clkout period in ps (40000 / multiplier)
# refclk period is 40000 ps, lines starting with # are skipped
mult_1        1   40000
mult_2        2   20000
mult_3        3   13333
mult_4        4   10000
mult_4_again  4   10000
mult_5        5   8000
mult_6        6   6666
mult_7        7   5714
mult_8        8   5000
mult_10       10  4000
mult_12       12  3333
mult_16       16  2500
mult_25       25  1600
mult_32       32  1250
mult_40       40  1000
mult_3_back   3   13333
mult_9        9   4444
mult_1_back   1   40000

// ==== tests/simulation_pll_tb.sv ====
`default_nettype none

// testbench for the simulation pll.
// refclk is fixed at 40 ns so clkout should run at 40000/M ps.
module simulation_pll_tb import sim_pll_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int  LOCK_COUNT    = 4;
	localparam int  TOLERANCE_PS  = 2;
	localparam real REF_HALF_NS   = 20.0;               // 40 ns refclk.
	localparam int  LOCK_LIMIT    = 1 + LOCK_COUNT + 2; // in refclk cycles.
	localparam real EDGE_LIMIT_NS = 100.0;              // longest clkout level.
	localparam int  AVG_CYCLES    = 64;
	localparam int  RAND_CASES    = 6;

	logic        refclk;
	logic        rst;
	multiplier_t multiplier;
	logic        clkout;
	logic        locked;

	int     errors;
	int     tests;
	int     test_errs; // error count when the current test began.
	integer seed;

	simulation_pll #(
		.LOCK_COUNT   (LOCK_COUNT),
		.TOLERANCE_PS (TOLERANCE_PS)
	) dut_i (
		.refclk     (refclk),
		.rst        (rst),
		.multiplier (multiplier),
		.clkout     (clkout),
		.locked     (locked)
	);

	initial begin
		refclk = 1'b0;
		forever #(REF_HALF_NS) refclk = ~refclk;
	end

	// period compare with 1 ps slack for the fraction dither.
	task automatic check_period(input string name, input period_ps_t expected,
			input period_ps_t actual);
		period_ps_t diff;
		diff = (actual > expected) ? actual - expected : expected - actual;
		if (diff > period_ps_t'(1)) begin
			$display("FAILED %s: expected %0d ps, actual %0d ps", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_lock(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
			errors++;
		end
	endtask

	// inputs change 1 ns after the rising edge.
	task automatic next_cycle();
		@(posedge refclk);
		#1;
	endtask

	task automatic start_test();
		tests++;
		test_errs = errors;
	endtask

	task automatic finish_test(input string name);
		if (errors == test_errs)
			$display("test %s ok", name);
		else
			$display("test %s: %0d errors", name, errors - test_errs);
	endtask

	// three reset cycles with both outputs checked low.
	task automatic reset_dut(input string name);
		start_test();
		rst = 1'b1;
		repeat (3) begin
			next_cycle();
			check_lock({name, " clkout in reset"}, 1'b0, clkout);
			check_lock({name, " locked in reset"}, 1'b0, locked);
		end
		rst = 1'b0;
		next_cycle();
		check_lock({name, " clkout after reset"}, 1'b0, clkout);
		check_lock({name, " locked after reset"}, 1'b0, locked);
		finish_test(name);
	endtask

	// wait up to EDGE_LIMIT_NS for clkout to reach a level.
	task automatic wait_clkout(input string name, input logic level, output bit ok);
		realtime t_start;
		t_start = $realtime;
		while (clkout !== level && ($realtime - t_start) < EDGE_LIMIT_NS)
			@(clkout or refclk);
		ok = (clkout === level);
		if (!ok) begin
			$display("clkout stopped toggling in %s", name);
			errors++;
		end
	endtask

	task automatic rising_edge(input string name, output realtime t, output bit ok);
		wait_clkout(name, 1'b0, ok);
		if (ok)
			wait_clkout(name, 1'b1, ok);
		t = $realtime; // exact edge time when ok.
	endtask

	task automatic wait_locked(input string name, output bit ok);
		int n;
		n = 0;
		while (locked !== 1'b1 && n < LOCK_LIMIT) begin
			next_cycle();
			n++;
		end
		ok = (locked === 1'b1);
		if (!ok) begin
			$display("locked never rose in %s", name);
			errors++;
		end
	endtask

	// average period over AVG_CYCLES and then one high time.
	task automatic measure_clkout(input string name, input period_ps_t expected);
		realtime    t0;
		realtime    t1;
		realtime    tl;
		bit         ok;
		int         i;
		period_ps_t avg;
		period_ps_t high;
		rising_edge(name, t0, ok); // drop a half cycle that may predate the change.
		if (ok)
			rising_edge(name, t0, ok);
		t1 = t0;
		for (i = 0; i < AVG_CYCLES && ok; i++)
			rising_edge(name, t1, ok);
		if (!ok)
			return;
		avg = period_ps_t'($rtoi((t1 - t0) * 1000.0 / AVG_CYCLES + 0.5));
		check_period({name, " period"}, expected, avg);
		wait_clkout(name, 1'b0, ok); // clkout is high since t1.
		if (!ok)
			return;
		tl   = $realtime;
		high = period_ps_t'($rtoi((tl - t1) * 1000.0 + 0.5));
		check_period({name, " high time"}, expected / 2, high);
	endtask

	// one multiplier case with the lock drop on a change.
	task automatic run_case(input string name, input multiplier_t m, input period_ps_t expected);
		bit changed;
		bit ok;
		start_test();
		next_cycle();
		changed    = (m !== multiplier);
		multiplier = m;
		next_cycle();
		if (changed)
			check_lock({name, " lock drop"}, 1'b0, locked);
		wait_locked(name, ok);
		if (ok)
			measure_clkout(name, expected);
		finish_test(name);
	endtask

	initial begin
		string  line;
		string  name;
		integer fd;
		integer m;
		integer p;
		integer r;
		bit     ok;
		int     k;

		errors     = 0;
		tests      = 0;
		test_errs  = 0;
		seed       = 44851;
		rst        = 1'b1;
		multiplier = multiplier_t'(4);

		reset_dut("reset"); // both outputs start low.

		// steady refclk and a fixed ratio.
		start_test();
		wait_locked("lock after reset", ok);
		if (ok) begin
			repeat (4) begin
				next_cycle();
				check_lock("lock held", 1'b1, locked);
			end
		end
		finish_test("lock after reset");

		fd = $fopen("tests/simulation_pll_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stim file");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line.getc(0) != "#") begin
					if ($sscanf(line, "%s %d %d", name, m, p) == 3)
						run_case(name, multiplier_t'(m), period_ps_t'(p));
				end
			end
			$fclose(fd);
		end

		next_cycle();
		reset_dut("reset_running"); // clkout toggling and locked high here.

		// seeded ratios from 1 to 16.
		for (k = 0; k < RAND_CASES; k++) begin
			r = $random(seed);
			m = (r & 32'h7fff_ffff) % 16 + 1;
			run_case($sformatf("rand_%0d_m%0d", k, m), multiplier_t'(m),
				period_ps_t'(40000 / m));
		end

		errors += dut_i.checker_i.fail_cnt; // bound assertion failures.
		$display("tests run %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire
